// File: core_pkg.sv
package core_pkg;

    // ==================================================
    // Core sizes
    // ==================================================
    parameter int FETCH_WIDTH = 2;
    parameter int XLEN        = 32;
    parameter int PREGS       = 64;
    parameter int ROB_ENTRIES = 64;
    parameter int CDB_PORTS   = 2;

    // Index widths derived from the sizes above
    parameter int LOG2_PREGS  = $clog2(PREGS);
    parameter int ROB_IDX_W   = $clog2(ROB_ENTRIES);

    // ==================================================
    // Field types
    // ==================================================
    typedef logic [LOG2_PREGS-1:0] preg_tag_t;
    typedef logic [4:0]            arch_reg_t;
    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [ROB_IDX_W-1:0]  rob_idx_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            alu_func_t;

    // ==================================================
    // Bundles
    // ==================================================
    // One renamed micro-op from rename
    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        alu_func_t alu_func;
        preg_tag_t prs1;
        preg_tag_t prs2;
        preg_tag_t prd;
        xlen_t     imm;
        xlen_t     pc;
        logic      rs1_valid;
        logic      rs2_valid;
        logic      rd_valid;
        // Op class flags
        logic      is_alu;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      is_cas;
        arch_reg_t arch_rs1;
        arch_reg_t arch_rs2;
        arch_reg_t arch_rd;
    } rename_uop_t;

    // One common data bus port
    typedef struct packed {
        logic      valid;
        preg_tag_t tag;
        xlen_t     value;
    } cdb_t;

    // Resolved source operand
    typedef struct packed {
        logic  ready;
        xlen_t value;
    } operand_t;

    // Reservation station entry request
    typedef struct packed {
        preg_tag_t   dst_tag;
        preg_tag_t   src1_tag;
        preg_tag_t   src2_tag;
        operand_t    src1;
        operand_t    src2;
        logic [11:0] op;
        rob_idx_t    rob_tag;
    } rs_alloc_t;

    // Reorder buffer entry request
    typedef struct packed {
        arch_reg_t arch_rd;
        preg_tag_t phys_rd;
        xlen_t     pc;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
    } rob_alloc_t;

    // Load/store unit request
    typedef struct packed {
        logic       is_load;
        logic [7:0] opcode;
        xlen_t      base_addr;
        xlen_t      offset;
        arch_reg_t  arch_rs1;
        arch_reg_t  arch_rs2;
        arch_reg_t  arch_rd;
        preg_tag_t  phys_rd;
        rob_idx_t   rob_idx;
        xlen_t      store_data;
        logic       store_data_ready;
    } lsu_req_t;

endpackage

// File: preg_file.sv
`timescale 1ns/1ps

module preg_file import core_pkg::*; #(
    parameter int FETCH_W = FETCH_WIDTH,
    parameter int PHYS_W  = LOG2_PREGS,
    parameter int XLEN_P  = XLEN
) (
    input  logic                                clk,
    input  logic                                reset,
    // Result buses
    input  cdb_t [CDB_PORTS-1:0]                cdb,
    // Destination allocation from the router
    input  logic [FETCH_W-1:0]                  alloc_dst_en,
    input  preg_tag_t [FETCH_W-1:0]             alloc_dst_tag,
    // Two read ports per lane
    input  preg_tag_t [FETCH_W-1:0][1:0]        rd_tag,
    output logic [FETCH_W-1:0][1:0][XLEN_P-1:0] rd_value,
    output logic [FETCH_W-1:0][1:0]             rd_ready
);

    localparam int NUM_REGS = 1 << PHYS_W;

    // ==================================================
    // Storage
    // ==================================================
    // Register values
    logic [XLEN_P-1:0]   value_q [NUM_REGS];
    // Scoreboard, one ready bit per register
    logic [NUM_REGS-1:0] ready_q;

    // ==================================================
    // Update
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Everything ready and zero out of reset
            for (int r = 0; r < NUM_REGS; r++) begin
                value_q[r] <= '0;
            end
            ready_q <= '1;
        end else begin
            // CDB results first, higher port last
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (cdb[p].valid && cdb[p].tag != '0) begin
                    value_q[cdb[p].tag] <= cdb[p].value;
                    ready_q[cdb[p].tag] <= 1'b1;
                end
            end
            // New destinations override a same-cycle CDB write
            for (int l = 0; l < FETCH_W; l++) begin
                if (alloc_dst_en[l] && alloc_dst_tag[l] != '0) begin
                    ready_q[alloc_dst_tag[l]] <= 1'b0;
                end
            end
        end
    end

    // ==================================================
    // Read ports
    // ==================================================
    // Plain array lookup, bypass lives in the resolvers
    always_comb begin
        for (int l = 0; l < FETCH_W; l++) begin
            for (int s = 0; s < 2; s++) begin
                rd_value[l][s] = value_q[rd_tag[l][s]];
                rd_ready[l][s] = ready_q[rd_tag[l][s]];
            end
        end
    end

endmodule

// File: operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve import core_pkg::*; #(
    parameter int XLEN_P = XLEN
) (
    // Lane micro-op
    input  rename_uop_t          uop,
    // Array read results
    input  logic [XLEN_P-1:0]    src1_value,
    input  logic                 src1_ready,
    input  logic [XLEN_P-1:0]    src2_value,
    input  logic                 src2_ready,
    // Same-cycle results for bypass
    input  cdb_t [CDB_PORTS-1:0] cdb,
    // Resolved operands
    output operand_t             src1,
    output operand_t             src2
);

    // ==================================================
    // Single source resolution
    // ==================================================
    function automatic operand_t resolve(
        input logic                 used,
        input preg_tag_t            tag,
        input logic [XLEN_P-1:0]    arr_value,
        input logic                 arr_ready,
        input logic [XLEN_P-1:0]    unused_value,
        input cdb_t [CDB_PORTS-1:0] bus
    );
        operand_t res;
        if (!used) begin
            // No register read, constant operand
            res.ready = 1'b1;
            res.value = unused_value;
        end else if (tag == '0) begin
            // Zero register
            res.ready = 1'b1;
            res.value = '0;
        end else begin
            // Array contents by default
            res.ready = arr_ready;
            res.value = arr_value;
            // Bypass, later port overrides earlier one
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (bus[p].valid && bus[p].tag == tag) begin
                    res.ready = 1'b1;
                    res.value = bus[p].value;
                end
            end
        end
        return res;
    endfunction

    // ==================================================
    // Sources
    // ==================================================
    // Source 1 has no immediate form
    assign src1 = resolve(uop.rs1_valid, uop.prs1, src1_value, src1_ready, '0, cdb);

    // Unused source 2 carries the immediate
    assign src2 = resolve(uop.rs2_valid, uop.prs2, src2_value, src2_ready,
                          uop.imm, cdb);

endmodule

// File: dispatch_router.sv
`timescale 1ns/1ps

module dispatch_router import core_pkg::*; #(
    parameter int FETCH_W = FETCH_WIDTH
) (
    // Group from rename plus resolved sources
    input  rename_uop_t [FETCH_W-1:0] uops,
    input  operand_t [FETCH_W-1:0]    src1,
    input  operand_t [FETCH_W-1:0]    src2,
    // Back-pressure and ROB slot indices
    input  logic                      rs_full,
    input  logic                      rob_alloc_ok,
    input  logic                      flush,
    input  rob_idx_t [FETCH_W-1:0]    rob_idx,
    // Hold request to rename
    output logic                      stall,
    // Reservation station
    output logic [FETCH_W-1:0]        rs_alloc_en,
    output rs_alloc_t [FETCH_W-1:0]   rs_alloc,
    // Reorder buffer
    output logic [FETCH_W-1:0]        rob_alloc_en,
    output rob_alloc_t [FETCH_W-1:0]  rob_alloc,
    // Load/store unit
    output logic                      lsu_alloc_en,
    output lsu_req_t                  lsu_req,
    // Scoreboard clears
    output logic [FETCH_W-1:0]        alloc_dst_en,
    output preg_tag_t [FETCH_W-1:0]   alloc_dst_tag
);

    localparam int CNT_W = $clog2(FETCH_W + 1);
    localparam int SEL_W = (FETCH_W > 1) ? $clog2(FETCH_W) : 1;

    // ==================================================
    // Memory op census
    // ==================================================
    logic [FETCH_W-1:0] mem_lane;
    logic [CNT_W-1:0]   mem_count;
    logic [SEL_W-1:0]   lsu_sel;
    logic               lsu_found;

    always_comb begin
        mem_count = '0;
        for (int i = 0; i < FETCH_W; i++) begin
            // CAS counts as a memory op too
            mem_lane[i] = uops[i].valid &&
                          (uops[i].is_load || uops[i].is_store || uops[i].is_cas);
            mem_count   = mem_count + CNT_W'(mem_lane[i]);
        end
    end

    // Lowest memory lane, the only one when not stalled
    always_comb begin
        lsu_sel   = '0;
        lsu_found = 1'b0;
        for (int i = 0; i < FETCH_W; i++) begin
            if (mem_lane[i] && !lsu_found) begin
                lsu_sel   = SEL_W'(i);
                lsu_found = 1'b1;
            end
        end
    end

    // ==================================================
    // Stall
    // ==================================================
    // Whole group holds on any blocker
    assign stall = rs_full || !rob_alloc_ok || flush || (mem_count > CNT_W'(1));

    // ==================================================
    // Per-lane ROB and RS allocation
    // ==================================================
    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            // Every valid lane takes a ROB slot
            rob_alloc_en[i] = uops[i].valid && !stall;
            // Only ALU and branch ops wait in the RS
            rs_alloc_en[i]  = rob_alloc_en[i] && (uops[i].is_alu || uops[i].is_branch);
            // Destination goes not-ready once dispatched
            alloc_dst_en[i]  = rob_alloc_en[i] && uops[i].rd_valid;
            alloc_dst_tag[i] = uops[i].prd;

            // ROB payload
            rob_alloc[i].arch_rd   = uops[i].arch_rd;
            rob_alloc[i].phys_rd   = uops[i].prd;
            rob_alloc[i].pc        = uops[i].pc;
            rob_alloc[i].is_load   = uops[i].is_load;
            rob_alloc[i].is_store  = uops[i].is_store;
            rob_alloc[i].is_branch = uops[i].is_branch;

            // RS payload, ROB slot doubles as the tag
            rs_alloc[i].dst_tag  = uops[i].prd;
            rs_alloc[i].src1_tag = uops[i].prs1;
            rs_alloc[i].src2_tag = uops[i].prs2;
            rs_alloc[i].src1     = src1[i];
            rs_alloc[i].src2     = src2[i];
            rs_alloc[i].op       = {uops[i].opcode, uops[i].alu_func};
            rs_alloc[i].rob_tag  = rob_idx[i];
        end
    end

    // ==================================================
    // LSU request
    // ==================================================
    assign lsu_alloc_en = lsu_found && !stall;

    always_comb begin
        // CAS reads memory, so it travels as a load
        lsu_req.is_load          = uops[lsu_sel].is_load || uops[lsu_sel].is_cas;
        lsu_req.opcode           = {uops[lsu_sel].opcode, 2'b00};
        // Address is base plus immediate offset
        lsu_req.base_addr        = src1[lsu_sel].value;
        lsu_req.offset           = uops[lsu_sel].imm;
        lsu_req.arch_rs1         = uops[lsu_sel].arch_rs1;
        lsu_req.arch_rs2         = uops[lsu_sel].arch_rs2;
        lsu_req.arch_rd          = uops[lsu_sel].arch_rd;
        lsu_req.phys_rd          = uops[lsu_sel].prd;
        lsu_req.rob_idx          = rob_idx[lsu_sel];
        // Store data may still be in flight
        lsu_req.store_data       = src2[lsu_sel].value;
        lsu_req.store_data_ready = src2[lsu_sel].ready;
    end

endmodule

// File: dispatch_unit.sv
`timescale 1ns/1ps

module dispatch_unit import core_pkg::*; #(
    parameter int FETCH_W = FETCH_WIDTH,
    parameter int PHYS_W  = LOG2_PREGS,
    parameter int XLEN_P  = XLEN
) (
    input  logic                      clk,
    input  logic                      reset,
    // From rename
    input  rename_uop_t [FETCH_W-1:0] uops,
    input  logic                      flush,
    // Result buses
    input  cdb_t [CDB_PORTS-1:0]      cdb,
    // From RS and ROB
    input  logic                      rs_full,
    input  logic                      rob_alloc_ok,
    input  rob_idx_t [FETCH_W-1:0]    rob_idx,
    // Outputs
    output logic                      stall,
    output logic [FETCH_W-1:0]        rs_alloc_en,
    output rs_alloc_t [FETCH_W-1:0]   rs_alloc,
    output logic [FETCH_W-1:0]        rob_alloc_en,
    output rob_alloc_t [FETCH_W-1:0]  rob_alloc,
    output logic                      lsu_alloc_en,
    output lsu_req_t                  lsu_req
);

    // ==================================================
    // Internal wiring
    // ==================================================
    preg_tag_t [FETCH_W-1:0][1:0]        rd_tag;
    logic [FETCH_W-1:0][1:0][XLEN_P-1:0] rd_value;
    logic [FETCH_W-1:0][1:0]             rd_ready;
    operand_t [FETCH_W-1:0]              src1;
    operand_t [FETCH_W-1:0]              src2;
    logic [FETCH_W-1:0]                  alloc_dst_en;
    preg_tag_t [FETCH_W-1:0]             alloc_dst_tag;

    // Register values and scoreboard
    preg_file #(
        .FETCH_W (FETCH_W),
        .PHYS_W  (PHYS_W),
        .XLEN_P  (XLEN_P)
    ) u_preg_file (
        .clk           (clk),
        .reset         (reset),
        .cdb           (cdb),
        .alloc_dst_en  (alloc_dst_en),
        .alloc_dst_tag (alloc_dst_tag),
        .rd_tag        (rd_tag),
        .rd_value      (rd_value),
        .rd_ready      (rd_ready)
    );

    // ==================================================
    // Lane resolvers
    // ==================================================
    for (genvar i = 0; i < FETCH_W; i++) begin : g_lane
        // Port 0 for source 1 and port 1 for source 2
        assign rd_tag[i][0] = uops[i].prs1;
        assign rd_tag[i][1] = uops[i].prs2;

        operand_resolve #(
            .XLEN_P (XLEN_P)
        ) u_resolve (
            .uop        (uops[i]),
            .src1_value (rd_value[i][0]),
            .src1_ready (rd_ready[i][0]),
            .src2_value (rd_value[i][1]),
            .src2_ready (rd_ready[i][1]),
            .cdb        (cdb),
            .src1       (src1[i]),
            .src2       (src2[i])
        );
    end

    // Routing and stall
    dispatch_router #(
        .FETCH_W (FETCH_W)
    ) u_router (
        .uops          (uops),
        .src1          (src1),
        .src2          (src2),
        .rs_full       (rs_full),
        .rob_alloc_ok  (rob_alloc_ok),
        .flush         (flush),
        .rob_idx       (rob_idx),
        .stall         (stall),
        .rs_alloc_en   (rs_alloc_en),
        .rs_alloc      (rs_alloc),
        .rob_alloc_en  (rob_alloc_en),
        .rob_alloc     (rob_alloc),
        .lsu_alloc_en  (lsu_alloc_en),
        .lsu_req       (lsu_req),
        .alloc_dst_en  (alloc_dst_en),
        .alloc_dst_tag (alloc_dst_tag)
    );

endmodule

// File: dispatch_assertions.sv
`timescale 1ns/1ps

module dispatch_assertions import core_pkg::*; #(
    parameter int FETCH_W = FETCH_WIDTH
) (
    input logic                      clk,
    input logic                      reset,
    input rename_uop_t [FETCH_W-1:0] uops,
    input logic                      flush,
    input cdb_t [CDB_PORTS-1:0]      cdb,
    input logic                      rs_full,
    input logic                      rob_alloc_ok,
    input rob_idx_t [FETCH_W-1:0]    rob_idx,
    input logic                      stall,
    input logic [FETCH_W-1:0]        rs_alloc_en,
    input rs_alloc_t [FETCH_W-1:0]   rs_alloc,
    input logic [FETCH_W-1:0]        rob_alloc_en,
    input rob_alloc_t [FETCH_W-1:0]  rob_alloc,
    input logic                      lsu_alloc_en,
    input lsu_req_t                  lsu_req
);

    localparam int SEL_W = (FETCH_W > 1) ? $clog2(FETCH_W) : 1;

    // Number of failed checks so far
    int                        fail_count = 0;
    // Shadow of the register values and scoreboard
    xlen_t                     shadow_value [PREGS];
    logic [PREGS-1:0]          shadow_ready;
    // Expected view of the current group
    int                        mem_count;
    logic [SEL_W-1:0]          mem_lane;
    logic                      exp_stall;
    logic                      exp_lsu_en;
    logic [FETCH_W-1:0]        exp_rob_en;
    logic [FETCH_W-1:0]        exp_rs_en;
    operand_t [FETCH_W-1:0]    src1_exp;
    operand_t [FETCH_W-1:0]    src2_exp;
    rob_alloc_t [FETCH_W-1:0]  exp_rob;
    rob_alloc_t [FETCH_W-1:0]  got_rob;
    rs_alloc_t [FETCH_W-1:0]   exp_rs;
    rs_alloc_t [FETCH_W-1:0]   got_rs;
    lsu_req_t                  exp_lsu;
    lsu_req_t                  got_lsu;

    // Source value as rename would expect it, newest CDB port first
    function automatic operand_t expected_operand(input logic used, input preg_tag_t tag,
                                                  input xlen_t unused_value);
        operand_t op;
        logic     hit;
        hit = 1'b0;
        op  = '{1'b1, unused_value};
        if (used && tag == '0) begin
            op = '{1'b1, '0};
        end else if (used) begin
            op = '{shadow_ready[tag], shadow_value[tag]};
            for (int p = CDB_PORTS - 1; p >= 0; p--) begin
                if (!hit && cdb[p].valid && cdb[p].tag == tag) begin
                    op  = '{1'b1, cdb[p].value};
                    hit = 1'b1;
                end
            end
        end
        return op;
    endfunction

    // ==================================================
    // Expected outputs
    // ==================================================
    always_comb begin
        mem_count = 0;
        mem_lane  = '0;
        for (int i = 0; i < FETCH_W; i++) begin
            if (uops[i].valid && (uops[i].is_load || uops[i].is_store || uops[i].is_cas)) begin
                // First memory lane is the LSU candidate
                if (mem_count == 0)
                    mem_lane = SEL_W'(i);
                mem_count++;
            end
        end
        exp_stall  = rs_full || !rob_alloc_ok || flush || (mem_count > 1);
        exp_lsu_en = !exp_stall && (mem_count == 1);
        for (int i = 0; i < FETCH_W; i++) begin
            exp_rob_en[i] = uops[i].valid && !exp_stall;
            exp_rs_en[i]  = exp_rob_en[i] && (uops[i].is_alu || uops[i].is_branch);
            src1_exp[i]   = expected_operand(uops[i].rs1_valid, uops[i].prs1, '0);
            src2_exp[i]   = expected_operand(uops[i].rs2_valid, uops[i].prs2, uops[i].imm);
            // Payloads only compared on valid lanes
            exp_rob[i] = '0;
            got_rob[i] = '0;
            exp_rs[i]  = '0;
            got_rs[i]  = '0;
            if (uops[i].valid) begin
                exp_rob[i] = '{uops[i].arch_rd, uops[i].prd, uops[i].pc, uops[i].is_load,
                               uops[i].is_store, uops[i].is_branch};
                exp_rs[i]  = '{uops[i].prd, uops[i].prs1, uops[i].prs2, src1_exp[i],
                               src2_exp[i], {uops[i].opcode, uops[i].alu_func}, rob_idx[i]};
                got_rob[i] = rob_alloc[i];
                got_rs[i]  = rs_alloc[i];
            end
        end
        exp_lsu = '0;
        got_lsu = '0;
        if (exp_lsu_en) begin
            // CAS reads memory as well
            exp_lsu.is_load          = uops[mem_lane].is_load || uops[mem_lane].is_cas;
            exp_lsu.base_addr        = src1_exp[mem_lane].value;
            exp_lsu.offset           = uops[mem_lane].imm;
            exp_lsu.arch_rs1         = uops[mem_lane].arch_rs1;
            exp_lsu.arch_rs2         = uops[mem_lane].arch_rs2;
            exp_lsu.arch_rd          = uops[mem_lane].arch_rd;
            exp_lsu.phys_rd          = uops[mem_lane].prd;
            exp_lsu.rob_idx          = rob_idx[mem_lane];
            exp_lsu.store_data       = src2_exp[mem_lane].value;
            exp_lsu.store_data_ready = src2_exp[mem_lane].ready;
            got_lsu.is_load          = lsu_req.is_load;
            got_lsu.base_addr        = lsu_req.base_addr;
            got_lsu.offset           = lsu_req.offset;
            got_lsu.arch_rs1         = lsu_req.arch_rs1;
            got_lsu.arch_rs2         = lsu_req.arch_rs2;
            got_lsu.arch_rd          = lsu_req.arch_rd;
            got_lsu.phys_rd          = lsu_req.phys_rd;
            got_lsu.rob_idx          = lsu_req.rob_idx;
            got_lsu.store_data       = lsu_req.store_data;
            got_lsu.store_data_ready = lsu_req.store_data_ready;
        end
    end

    // ==================================================
    // Shadow register state
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < PREGS; r++) begin
                shadow_value[r] <= '0;
            end
            shadow_ready <= '1;
        end else begin
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (cdb[p].valid && cdb[p].tag != '0) begin
                    shadow_value[cdb[p].tag] <= cdb[p].value;
                    shadow_ready[cdb[p].tag] <= 1'b1;
                end
            end
            // Dispatched destinations go pending, even over a CDB write
            for (int i = 0; i < FETCH_W; i++) begin
                if (exp_rob_en[i] && uops[i].rd_valid && uops[i].prd != '0)
                    shadow_ready[uops[i].prd] <= 1'b0;
            end
        end
    end

    // ==================================================
    // Checks at mid-cycle, inputs settled
    // ==================================================
    a_stall: assert property (@(negedge clk) disable iff (reset) stall == exp_stall)
        else begin
            fail_count = fail_count + 1;
            $error("FAIL stall got %h exp %h", stall, exp_stall);
        end

    a_enables: assert property (@(negedge clk) disable iff (reset)
        {rob_alloc_en, rs_alloc_en, lsu_alloc_en} == {exp_rob_en, exp_rs_en, exp_lsu_en})
        else begin
            fail_count = fail_count + 1;
            $error("FAIL rob_alloc_en %h exp %h rs_alloc_en %h exp %h lsu_alloc_en %h exp %h",
                   rob_alloc_en, exp_rob_en, rs_alloc_en, exp_rs_en, lsu_alloc_en, exp_lsu_en);
        end

    a_rob: assert property (@(negedge clk) disable iff (reset) got_rob == exp_rob)
        else begin
            fail_count = fail_count + 1;
            $error("FAIL rob_alloc got %h exp %h", got_rob, exp_rob);
        end

    // Tags, op and both resolved sources
    a_rs: assert property (@(negedge clk) disable iff (reset) got_rs == exp_rs)
        else begin
            fail_count = fail_count + 1;
            $error("FAIL rs_alloc got %h exp %h", got_rs, exp_rs);
        end

    a_lsu: assert property (@(negedge clk) disable iff (reset) got_lsu == exp_lsu)
        else begin
            fail_count = fail_count + 1;
            $error("FAIL lsu_req got %h exp %h", got_lsu, exp_lsu);
        end

endmodule

bind dispatch_unit dispatch_assertions #(.FETCH_W(FETCH_W)) u_chk (.*);

// File: dispatch_tb.sv
`timescale 1ns/1ps

module dispatch_tb import core_pkg::*; ();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 20;
    localparam int RANDOM_CYCLES   = 400;

    // Op classes
    localparam int K_ALU    = 0;
    localparam int K_BRANCH = 1;
    localparam int K_LOAD   = 2;
    localparam int K_STORE  = 3;
    localparam int K_CAS    = 4;

    logic                          clk;
    logic                          reset;
    rename_uop_t [FETCH_WIDTH-1:0] uops;
    logic                          flush;
    cdb_t [CDB_PORTS-1:0]          cdb;
    logic                          rs_full;
    logic                          rob_alloc_ok;
    rob_idx_t [FETCH_WIDTH-1:0]    rob_idx;
    logic                          stall;
    logic [FETCH_WIDTH-1:0]        rs_alloc_en;
    rs_alloc_t [FETCH_WIDTH-1:0]   rs_alloc;
    logic [FETCH_WIDTH-1:0]        rob_alloc_en;
    rob_alloc_t [FETCH_WIDTH-1:0]  rob_alloc;
    logic                          lsu_alloc_en;
    lsu_req_t                      lsu_req;
    int                            seed;

    dispatch_unit #(.FETCH_W(FETCH_WIDTH)) u_dut (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // Small tag range so lanes and CDB ports collide often
    function automatic preg_tag_t rand_tag();
        return preg_tag_t'(rand_word() & 32'hf);
    endfunction

    function automatic rename_uop_t make_uop(input int kind, input preg_tag_t s1,
                                             input preg_tag_t s2, input preg_tag_t d);
        rename_uop_t u;
        logic [31:0] r;
        r           = rand_word();
        u           = '0;
        u.valid     = 1'b1;
        u.opcode    = r[5:0];
        u.alu_func  = r[11:6];
        u.prs1      = s1;
        u.prs2      = s2;
        u.prd       = d;
        u.imm       = rand_word();
        u.pc        = {r[31:12], 12'h0};
        u.arch_rs1  = r[16:12];
        u.arch_rs2  = r[21:17];
        u.arch_rd   = r[26:22];
        u.rs1_valid = 1'b1;
        // Loads take the immediate in place of source 2
        u.rs2_valid = (kind != K_LOAD);
        u.rd_valid  = (kind == K_ALU || kind == K_LOAD || kind == K_CAS);
        u.is_alu    = (kind == K_ALU);
        u.is_branch = (kind == K_BRANCH);
        u.is_load   = (kind == K_LOAD);
        u.is_store  = (kind == K_STORE);
        u.is_cas    = (kind == K_CAS);
        return u;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        uops         = '0;
        cdb          = '0;
        flush        = 1'b0;
        rs_full      = 1'b0;
        rob_alloc_ok = 1'b1;
        for (int l = 0; l < FETCH_WIDTH; l++) begin
            rob_idx[l] = rob_idx_t'(l + 3);
        end
    endtask

    task automatic random_group();
        logic [31:0] r;
        for (int l = 0; l < FETCH_WIDTH; l++) begin
            r                 = rand_word();
            uops[l]           = make_uop(int'(r[7:0]) % 5, rand_tag(), rand_tag(), rand_tag());
            uops[l].valid     = (r[9:8] != 2'b00);
            uops[l].rs1_valid = r[10] | r[11];
            uops[l].rs2_valid = r[12];
            uops[l].rd_valid  = r[13] | r[14];
            rob_idx[l]        = rob_idx_t'(r[31:16]);
        end
        for (int p = 0; p < CDB_PORTS; p++) begin
            r            = rand_word();
            cdb[p].valid = r[0] | r[1];
            cdb[p].tag   = rand_tag();
            cdb[p].value = rand_word();
        end
        // Rare back-pressure
        r            = rand_word();
        rs_full      = (r[2:0] == 3'b000);
        rob_alloc_ok = (r[5:3] != 3'b000);
        flush        = (r[9:6] == 4'b0000);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        seed  = 32'h34cc;
        reset = 1'b1;
        clear_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // Idle group right out of reset
        next_cycle();
        // Fresh registers, zero tag on lane 1
        uops[0] = make_uop(K_ALU, 6'd5, 6'd9, 6'd20);
        uops[1] = make_uop(K_ALU, 6'd7, 6'd0, 6'd21);
        next_cycle();
        // Tag 20 pending, tag 21 bypassed
        clear_inputs();
        uops[0] = make_uop(K_ALU, 6'd20, 6'd3, 6'd0);
        uops[1] = make_uop(K_BRANCH, 6'd21, 6'd4, 6'd0);
        cdb[0]  = '{1'b1, 6'd21, 32'hcafe_0001};
        next_cycle();
        // Both ports on tag 20
        clear_inputs();
        uops[0] = make_uop(K_ALU, 6'd21, 6'd21, 6'd0);
        uops[1] = make_uop(K_ALU, 6'd20, 6'd2, 6'd0);
        cdb[0]  = '{1'b1, 6'd20, 32'h1111_aaaa};
        cdb[1]  = '{1'b1, 6'd20, 32'h2222_bbbb};
        next_cycle();
        // CDB write and allocation on tag 30 together
        clear_inputs();
        uops[0] = make_uop(K_ALU, 6'd20, 6'd1, 6'd30);
        cdb[0]  = '{1'b1, 6'd30, 32'h3030_3030};
        next_cycle();
        clear_inputs();
        uops[0] = make_uop(K_ALU, 6'd30, 6'd20, 6'd0);
        next_cycle();
        // One blocker at a time
        for (int b = 0; b < 4; b++) begin
            clear_inputs();
            uops[0]      = make_uop((b == 3) ? K_LOAD : K_ALU, 6'd1, 6'd2, 6'd40);
            uops[1]      = make_uop((b == 3) ? K_STORE : K_ALU, 6'd3, 6'd4, 6'd41);
            rs_full      = (b == 0);
            rob_alloc_ok = (b != 1);
            flush        = (b == 2);
            next_cycle();
        end
        // Held groups left 40 and 41 ready
        clear_inputs();
        uops[0] = make_uop(K_ALU, 6'd40, 6'd41, 6'd0);
        next_cycle();
        // Each memory kind alone, store on lane 0
        for (int k = K_LOAD; k <= K_CAS; k++) begin
            clear_inputs();
            uops[0] = make_uop(K_ALU, 6'd8, 6'd9, 6'd10);
            uops[1] = make_uop(k, 6'd20, 6'd30, 6'd11);
            cdb[1]  = '{1'b1, 6'd30, rand_word()};
            if (k == K_STORE)
                uops = {uops[0], uops[1]};
            next_cycle();
        end
        // Unused sources
        clear_inputs();
        uops[0]           = make_uop(K_ALU, 6'd30, 6'd20, 6'd0);
        uops[0].rs1_valid = 1'b0;
        uops[0].rs2_valid = 1'b0;
        uops[1]           = make_uop(K_LOAD, 6'd0, 6'd0, 6'd12);
        next_cycle();
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            random_group();
            next_cycle();
        end
        clear_inputs();
        next_cycle();
        @(negedge clk);
        #1;
        if (u_dut.u_chk.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "Assertion checks failed");
        end
    end

    // Stop at the first failed check
    initial begin
        wait (u_dut.u_chk.fail_count != 0);
        $display("tests failed");
        $fatal(1, "An assertion check failed, see the error above");
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD * 2);
        $display("tests failed");
        $fatal(1, "Timeout, the run did not reach its end");
    end

endmodule

// File: verilog.f
core_pkg.sv
preg_file.sv
operand_resolve.sv
dispatch_router.sv
dispatch_unit.sv
dispatch_assertions.sv
dispatch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the dispatch testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module dispatch_tb \
    -f verilog.f

# Keep running past assertion errors so the testbench ends the run
./obj_dir/Vdispatch_tb +verilator+error+limit+1000
